//--- Makefile
# Verilator build and regression run for the instruction tracer

SIM       ?= verilator
TOP       ?= tb_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD_DIR)
RUN_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test: failure found in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test: no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/ex_tracker.sv
// EX stage tracking of the ID queue head.
// Collects the last matching register write and the first granted data
// access, and forwards the merged entry on ex_valid or wb_bypass.
// Updates seen in the advance cycle are merged combinationally.

`timescale 1ns/1ns
`default_nettype none

module ex_tracker import trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  id_entry_t             ex_head,
  input  logic                  ex_head_valid,
  input  logic                  ex_valid,
  input  logic                  wb_bypass,
  input  logic                  ex_reg_we,
  input  logic [REG_ADDR_W-1:0] ex_reg_addr,
  input  logic [XLEN-1:0]       ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic                  ex_data_we,
  input  logic [XLEN-1:0]       ex_data_addr,
  output logic                  ex_pop,
  output logic                  wb_push,
  output ex_entry_t             wb_entry
);

  logic [XLEN-1:0] rd_wdata_q;
  logic            rd_seen_q;
  logic            mem_valid_q;
  logic            mem_we_q;
  logic [XLEN-1:0] mem_addr_q;
  logic            rd_match;
  logic            mem_hit;

  // writes to x0 never count
  assign rd_match = ex_head_valid & ex_reg_we & ex_head.rd_used &
                    (ex_reg_addr == ex_head.rd) & (ex_head.rd != '0);
  // only the first granted access is kept
  assign mem_hit  = ex_head_valid & ex_data_req & ex_data_gnt & ~mem_valid_q;

  assign ex_pop  = ex_head_valid & (ex_valid | wb_bypass);
  assign wb_push = ex_pop;

  assign wb_entry = '{id:        ex_head,
                      rd_wdata:  rd_match ? ex_reg_wdata : rd_wdata_q,
                      rd_seen:   rd_match | rd_seen_q,
                      mem_valid: mem_hit | mem_valid_q,
                      mem_we:    mem_hit ? ex_data_we : mem_we_q,
                      mem_addr:  mem_hit ? ex_data_addr : mem_addr_q};

  ////////////////////
  // side registers of the current head
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_wdata_q  <= '0;
      rd_seen_q   <= 1'b0;
      mem_valid_q <= 1'b0;
      mem_we_q    <= 1'b0;
      mem_addr_q  <= '0;
    end else if (ex_pop) begin
      // next head starts clean
      rd_wdata_q  <= '0;
      rd_seen_q   <= 1'b0;
      mem_valid_q <= 1'b0;
      mem_we_q    <= 1'b0;
      mem_addr_q  <= '0;
    end else begin
      if (rd_match) begin
        rd_wdata_q <= ex_reg_wdata;
        rd_seen_q  <= 1'b1;
      end
      if (mem_hit) begin
        mem_valid_q <= 1'b1;
        mem_we_q    <= ex_data_we;
        mem_addr_q  <= ex_data_addr;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/id_capture.sv
// ID stage capture: free-running cycle stamp and capture condition.
// The push is combinational in the capture cycle; the stamp is 0 in the
// first cycle after reset release and wraps silently.

`timescale 1ns/1ns
`default_nettype none

module id_capture import trace_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] instr,
  input  logic            is_decoding,
  input  logic            id_valid,
  input  logic            pipe_flush,
  input  logic            mret,
  input  logic            uret,
  input  logic            dret,
  input  logic            ecall,
  input  logic            ebreak,
  output logic            id_push,
  output id_entry_t       id_entry
);

  logic [CYCLE_W-1:0]    cycle_cnt;
  instr_class_t          instr_class;
  logic [REG_ADDR_W-1:0] rd;
  logic                  rd_used;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // flush and exception returns leave ID even without id_valid
  assign id_push = is_decoding &
                   (id_valid | pipe_flush | mret | uret | dret | ecall | ebreak);

  instr_classifier classifier_i (
    .instr       (instr),
    .instr_class (instr_class),
    .rd          (rd),
    .rd_used     (rd_used)
  );

  assign id_entry = '{cycle:       cycle_cnt,
                      pc:          pc,
                      instr:       instr,
                      instr_class: instr_class,
                      rd:          rd,
                      rd_used:     rd_used};

endmodule

`default_nettype wire

//--- source/instr_classifier.sv
// Combinational RV32I format decode for tracing.
// Only the major opcode and funct3/funct7 are checked; M-extension and
// custom encodings on OPC_OP are reported as CLS_INVALID.

`timescale 1ns/1ns
`default_nettype none

module instr_classifier import trace_pkg::*; (
  input  logic [XLEN-1:0]       instr,
  output instr_class_t          instr_class,
  output logic [REG_ADDR_W-1:0] rd,
  output logic                  rd_used
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];

  always_comb begin
    instr_class = CLS_INVALID;
    if (instr == 32'h0000_0013) begin
      // canonical addi x0, x0, 0
      instr_class = CLS_NOP;
    end else begin
      case (opcode)
        OPC_OP: begin
          if (funct7 == 7'b0000000) begin
            instr_class = CLS_R;
          end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
            // sub and sra
            instr_class = CLS_R;
          end
        end
        OPC_OPIMM: instr_class = CLS_I;
        OPC_LOAD: begin
          if (funct3 != 3'b011 && funct3 != 3'b110 && funct3 != 3'b111) begin
            instr_class = CLS_LOAD;
          end
        end
        OPC_STORE: begin
          if (funct3 < 3'd3) begin
            instr_class = CLS_STORE;
          end
        end
        OPC_BRANCH: begin
          if (funct3 != 3'b010 && funct3 != 3'b011) begin
            instr_class = CLS_BRANCH;
          end
        end
        OPC_LUI, OPC_AUIPC: instr_class = CLS_U;
        OPC_JAL:            instr_class = CLS_J;
        OPC_JALR:           instr_class = CLS_I;
        OPC_SYSTEM: begin
          // funct3 100 is unused, treated like ecall/ebreak/xret
          if (funct3 != 3'b000 && funct3 != 3'b100) begin
            instr_class = CLS_CSR;
          end else begin
            instr_class = CLS_SYSTEM;
          end
        end
        OPC_FENCE: instr_class = CLS_FENCE;
        default:   instr_class = CLS_INVALID;
      endcase
    end
  end

  // classes that write a destination register
  always_comb begin
    case (instr_class)
      CLS_R, CLS_I, CLS_LOAD, CLS_U, CLS_J, CLS_CSR: rd_used = 1'b1;
      default:                                       rd_used = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/trace_fifo.sv
// Synchronous FIFO for trace entries with a first-word head view.
// DEPTH must be a power of two, 2 or more. No back-pressure: a push into
// a full queue without a pop is dropped and sets the sticky overflow.

`timescale 1ns/1ns
`default_nettype none

module trace_fifo #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 4
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  entry_t push_data,
  input  logic   pop,
  output entry_t head,
  output logic   head_valid,
  output logic   overflow
);

  localparam int PTR_W = $clog2(DEPTH);

  entry_t           mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == (PTR_W+1)'(DEPTH));
  assign head_valid = (count != '0);
  assign do_pop     = pop & head_valid;
  // a pop frees the slot for the same-cycle push
  assign do_push    = push & (~full | do_pop);
  assign head       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
      if (push && !do_push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/trace_pkg.sv
// Shared widths, opcodes and queue entry layouts for the instruction tracer.
// RV32I base opcodes only; no compressed, FP or custom extensions.
// Register indices are 5 bits, so FP registers cannot be told apart.

`default_nettype none

package trace_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CYCLE_W    = 32;

  ////////////////////
  // major opcodes
  ////////////////////

  typedef logic [6:0] opcode_t;

  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OPIMM  = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_FENCE  = 7'b0001111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // instruction format class
  typedef enum logic [3:0] {
    CLS_R       = 4'd0,
    CLS_I       = 4'd1,
    CLS_LOAD    = 4'd2,
    CLS_STORE   = 4'd3,
    CLS_BRANCH  = 4'd4,
    CLS_U       = 4'd5,
    CLS_J       = 4'd6,
    CLS_CSR     = 4'd7,
    CLS_SYSTEM  = 4'd8,
    CLS_FENCE   = 4'd9,
    CLS_NOP     = 4'd10,
    CLS_INVALID = 4'd11
  } instr_class_t;

  ////////////////////
  // queue entries
  ////////////////////

  // entry as captured in ID
  typedef struct packed {
    logic [CYCLE_W-1:0]    cycle;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       instr;
    instr_class_t          instr_class;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_used;
  } id_entry_t;

  // entry after EX, with write-back and first data access
  typedef struct packed {
    id_entry_t       id;
    logic [XLEN-1:0] rd_wdata;
    logic            rd_seen;
    logic            mem_valid;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;
  } ex_entry_t;

endpackage

`default_nettype wire

//--- source/tracer_top.sv
// Instruction trace unit top level: ID capture, EX and WB queues.
// Observe-only; it never stalls the core. TRACE_DEPTH sets both queue
// depths and must be a power of two, 2 or more.

`timescale 1ns/1ns
`default_nettype none

module tracer_top import trace_pkg::*; #(
  parameter int TRACE_DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [XLEN-1:0]       pc,
  input  logic [XLEN-1:0]       instr,
  input  logic                  is_decoding,
  input  logic                  id_valid,
  input  logic                  pipe_flush,
  input  logic                  mret,
  input  logic                  uret,
  input  logic                  dret,
  input  logic                  ecall,
  input  logic                  ebreak,
  input  logic                  ex_valid,
  input  logic                  wb_bypass,
  input  logic                  ex_reg_we,
  input  logic [REG_ADDR_W-1:0] ex_reg_addr,
  input  logic [XLEN-1:0]       ex_reg_wdata,
  input  logic                  ex_data_req,
  input  logic                  ex_data_gnt,
  input  logic                  ex_data_we,
  input  logic [XLEN-1:0]       ex_data_addr,
  input  logic                  wb_valid,
  input  logic                  wb_reg_we,
  input  logic [REG_ADDR_W-1:0] wb_reg_addr,
  input  logic [XLEN-1:0]       wb_reg_wdata,
  output logic                  trace_valid,
  output logic [CYCLE_W-1:0]    trace_cycle,
  output logic [XLEN-1:0]       trace_pc,
  output logic [XLEN-1:0]       trace_instr,
  output instr_class_t          trace_class,
  output logic [REG_ADDR_W-1:0] trace_rd,
  output logic                  trace_rd_seen,
  output logic [XLEN-1:0]       trace_rd_wdata,
  output logic                  trace_mem_valid,
  output logic                  trace_mem_we,
  output logic [XLEN-1:0]       trace_mem_addr,
  output logic                  trace_overflow
);

  logic      id_push;
  id_entry_t id_entry;
  id_entry_t ex_head;
  logic      ex_head_valid;
  logic      ex_pop;
  logic      id_overflow;
  logic      wb_push;
  ex_entry_t wb_entry;
  ex_entry_t wb_head;
  logic      wb_head_valid;
  logic      wb_pop;
  logic      wb_overflow;

  id_capture id_capture_i (
    .clk, .rst_n, .pc, .instr, .is_decoding, .id_valid, .pipe_flush,
    .mret, .uret, .dret, .ecall, .ebreak,
    .id_push  (id_push),
    .id_entry (id_entry)
  );

  // ID to EX queue
  trace_fifo #(.entry_t(id_entry_t), .DEPTH(TRACE_DEPTH)) id_q (
    .clk, .rst_n,
    .push       (id_push),
    .push_data  (id_entry),
    .pop        (ex_pop),
    .head       (ex_head),
    .head_valid (ex_head_valid),
    .overflow   (id_overflow)
  );

  ex_tracker ex_tracker_i (
    .clk, .rst_n, .ex_head, .ex_head_valid, .ex_valid, .wb_bypass,
    .ex_reg_we, .ex_reg_addr, .ex_reg_wdata,
    .ex_data_req, .ex_data_gnt, .ex_data_we, .ex_data_addr,
    .ex_pop, .wb_push, .wb_entry
  );

  // EX to WB queue
  trace_fifo #(.entry_t(ex_entry_t), .DEPTH(TRACE_DEPTH)) wb_q (
    .clk, .rst_n,
    .push       (wb_push),
    .push_data  (wb_entry),
    .pop        (wb_pop),
    .head       (wb_head),
    .head_valid (wb_head_valid),
    .overflow   (wb_overflow)
  );

  wb_tracker wb_tracker_i (
    .clk, .rst_n, .wb_head, .wb_head_valid, .wb_valid,
    .wb_reg_we, .wb_reg_addr, .wb_reg_wdata, .id_overflow, .wb_overflow,
    .wb_pop, .trace_valid, .trace_cycle, .trace_pc, .trace_instr,
    .trace_class, .trace_rd, .trace_rd_seen, .trace_rd_wdata,
    .trace_mem_valid, .trace_mem_we, .trace_mem_addr, .trace_overflow
  );

endmodule

`default_nettype wire

//--- source/wb_tracker.sv
// WB stage tracking of the WB queue head and trace record output.
// A WB register write overrides the value captured in EX. The record is
// registered, so trace_valid pulses one cycle after wb_valid.
// trace_overflow is combinational from the two sticky queue flags.

`timescale 1ns/1ns
`default_nettype none

module wb_tracker import trace_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_entry_t             wb_head,
  input  logic                  wb_head_valid,
  input  logic                  wb_valid,
  input  logic                  wb_reg_we,
  input  logic [REG_ADDR_W-1:0] wb_reg_addr,
  input  logic [XLEN-1:0]       wb_reg_wdata,
  input  logic                  id_overflow,
  input  logic                  wb_overflow,
  output logic                  wb_pop,
  output logic                  trace_valid,
  output logic [CYCLE_W-1:0]    trace_cycle,
  output logic [XLEN-1:0]       trace_pc,
  output logic [XLEN-1:0]       trace_instr,
  output instr_class_t          trace_class,
  output logic [REG_ADDR_W-1:0] trace_rd,
  output logic                  trace_rd_seen,
  output logic [XLEN-1:0]       trace_rd_wdata,
  output logic                  trace_mem_valid,
  output logic                  trace_mem_we,
  output logic [XLEN-1:0]       trace_mem_addr,
  output logic                  trace_overflow
);

  logic [XLEN-1:0] wb_wdata_q;
  logic            wb_seen_q;
  logic            wb_match;

  assign wb_match = wb_head_valid & wb_reg_we & wb_head.id.rd_used &
                    (wb_reg_addr == wb_head.id.rd) & (wb_head.id.rd != '0);
  assign wb_pop   = wb_head_valid & wb_valid;

  assign trace_overflow = id_overflow | wb_overflow;

  // late write matches of the current head
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_wdata_q <= '0;
      wb_seen_q  <= 1'b0;
    end else if (wb_pop) begin
      wb_wdata_q <= '0;
      wb_seen_q  <= 1'b0;
    end else if (wb_match) begin
      wb_wdata_q <= wb_reg_wdata;
      wb_seen_q  <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= wb_pop;
    end
  end

  ////////////////////
  // record payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (wb_pop) begin
      trace_cycle     <= wb_head.id.cycle;
      trace_pc        <= wb_head.id.pc;
      trace_instr     <= wb_head.id.instr;
      trace_class     <= wb_head.id.instr_class;
      trace_rd        <= wb_head.id.rd;
      trace_rd_seen   <= wb_head.rd_seen | wb_seen_q | wb_match;
      // newest source wins: this cycle, earlier WB, then EX
      trace_rd_wdata  <= wb_match  ? wb_reg_wdata :
                         wb_seen_q ? wb_wdata_q   : wb_head.rd_wdata;
      trace_mem_valid <= wb_head.mem_valid;
      trace_mem_we    <= wb_head.mem_we;
      trace_mem_addr  <= wb_head.mem_addr;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
source/trace_pkg.sv
source/instr_classifier.sv
source/id_capture.sv
source/trace_fifo.sv
source/ex_tracker.sv
source/wb_tracker.sv
source/tracer_top.sv
testbench/tb_clock_gen.sv
testbench/tracer_checker.sv
testbench/tb_top.sv

//--- testbench/tb_clock_gen.sv
// Clock and reset source for the testbench.
// Reset is held low for RESET_CYCLES rising edges and is released on a
// falling edge, so the first active cycle starts cleanly.

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_top.sv
// Testbench for the instruction tracer.
// A cycle model of the ID queue, EX stage and WB queue predicts every
// trace record; inputs change on falling edges, outputs are checked on
// the next falling edge. Expected classes come from the instruction
// generator, which builds each word for a chosen class.

`timescale 1ns/1ns
`default_nettype none

module tb_top import trace_pkg::*; ();

  localparam int DEPTH       = 4;
  localparam int RAND_CYCLES = 200;
  localparam int N_INSTR     = 12 + RAND_CYCLES + DEPTH + 2;
  localparam int TIMEOUT_NS  = (N_INSTR * 20 + 200) * 10;

  typedef struct packed {
    logic [31:0]  cycle;
    logic [31:0]  pc;
    logic [31:0]  instr;
    instr_class_t cls;
    logic [4:0]   rd;
    logic         rd_used;
    logic [31:0]  rd_wdata;
    logic         rd_seen;
    logic         mem_valid;
    logic         mem_we;
    logic [31:0]  mem_addr;
  } rec_t;

  logic clk, rst_n;
  logic [31:0] pc, instr;
  logic is_decoding, id_valid, pipe_flush, mret, uret, dret, ecall, ebreak;
  logic ex_valid, wb_bypass, ex_reg_we, ex_data_req, ex_data_gnt, ex_data_we;
  logic [4:0] ex_reg_addr, wb_reg_addr;
  logic [31:0] ex_reg_wdata, ex_data_addr, wb_reg_wdata;
  logic wb_valid, wb_reg_we;
  logic trace_valid, trace_rd_seen, trace_mem_valid, trace_mem_we, trace_overflow;
  logic [31:0] trace_cycle, trace_pc, trace_instr, trace_rd_wdata, trace_mem_addr;
  instr_class_t trace_class;
  logic [4:0] trace_rd;

  // model state
  rec_t id_q[$];
  rec_t wb_q[$];
  rec_t ex_side = '0;
  rec_t wb_side = '0;
  rec_t exp_rec = '0;
  logic exp_valid = 1'b0;
  logic exp_ovf = 1'b0;
  logic stall_free = 1'b0;
  logic [31:0] cyc = 32'd0;
  logic [31:0] pc_next = 32'h0000_1000;
  logic [31:0] lcg_state = 32'h1ba;
  instr_class_t cur_cls = CLS_NOP;
  int value_errors = 0;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) clock_gen_i (.clk(clk), .rst_n(rst_n));

  tracer_top #(.TRACE_DEPTH(DEPTH)) dut_i (.*);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic uses_rd(input instr_class_t c);
    return c inside {CLS_R, CLS_I, CLS_LOAD, CLS_U, CLS_J, CLS_CSR};
  endfunction

  // builds a word that decodes to the given class
  function automatic logic [31:0] make_instr(input instr_class_t cls, input logic [4:0] rd,
                                             input logic [31:0] r);
    logic [2:0]  f3;
    logic [31:0] w;
    f3 = r[14:12];
    case (cls)
      CLS_R:     w = {7'b0000000, r[24:12], rd, OPC_OP};
      CLS_I: begin
        w = {r[31:12], rd, OPC_OPIMM};
        if (w == 32'h0000_0013) begin
          w[20] = 1'b1;
        end
      end
      CLS_LOAD: begin
        f3 = (f3 == 3'b011 || f3[2:1] == 2'b11) ? 3'b001 : f3;
        w  = {r[31:15], f3, rd, OPC_LOAD};
      end
      CLS_STORE: begin
        f3 = (f3 > 3'd2) ? 3'd2 : f3;
        w  = {r[31:15], f3, rd, OPC_STORE};
      end
      CLS_BRANCH: begin
        f3 = (f3[2:1] == 2'b01) ? 3'b000 : f3;
        w  = {r[31:15], f3, rd, OPC_BRANCH};
      end
      CLS_U:      w = {r[31:12], rd, r[0] ? OPC_LUI : OPC_AUIPC};
      CLS_J:      w = {r[31:12], rd, OPC_JAL};
      CLS_CSR: begin
        f3 = (f3[1:0] == 2'b00) ? {f3[2], 2'b01} : f3;
        w  = {r[31:15], f3, rd, OPC_SYSTEM};
      end
      CLS_SYSTEM: w = {r[31:15], r[14], 2'b00, rd, OPC_SYSTEM};
      CLS_FENCE:  w = {r[31:12], rd, OPC_FENCE};
      CLS_NOP:    w = 32'h0000_0013;
      // M-extension encoding, not accepted on OPC_OP
      default:    w = {7'b0000001, r[24:12], rd, OPC_OP};
    endcase
    return w;
  endfunction

  task automatic init_inputs();
    pc = '0;
    instr = '0;
    {is_decoding, id_valid, pipe_flush, mret, uret, dret, ecall, ebreak} = '0;
    {ex_valid, wb_bypass, ex_reg_we, ex_data_req, ex_data_gnt, ex_data_we} = '0;
    ex_reg_addr = '0;
    ex_reg_wdata = '0;
    ex_data_addr = '0;
    {wb_valid, wb_reg_we} = '0;
    wb_reg_addr = '0;
    wb_reg_wdata = '0;
  endtask

  task automatic clear_capture();
    is_decoding = 1'b0;
    id_valid = 1'b0;
    pipe_flush = 1'b0;
    ecall = 1'b0;
  endtask

  task automatic drive_capture(input instr_class_t cls);
    logic [31:0] r;
    logic [4:0]  rd;
    r = next_rand();
    rd = (r[7:5] == 3'd0) ? 5'd0 : r[4:0];
    cur_cls = cls;
    pc = pc_next;
    pc_next = pc_next + 32'd4;
    instr = make_instr(cls, rd, next_rand());
    clear_capture();
    is_decoding = 1'b1;
    id_valid = 1'b1;
  endtask

  // register writes aimed at the stage heads half of the time
  task automatic drive_side();
    logic [31:0] r;
    r = next_rand();
    ex_reg_we = r[31];
    ex_reg_addr = (r[30] && id_q.size() > 0) ? id_q[0].rd : r[4:0];
    ex_reg_wdata = next_rand();
    ex_data_req = r[29];
    ex_data_gnt = r[28];
    ex_data_we = r[27];
    ex_data_addr = next_rand();
    wb_reg_we = r[26];
    wb_reg_addr = (r[25] && wb_q.size() > 0) ? wb_q[0].rd : r[9:5];
    wb_reg_wdata = next_rand();
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic check_outputs();
    compare_field("trace_valid", 32'(trace_valid), 32'(exp_valid));
    compare_field("trace_overflow", 32'(trace_overflow), 32'(exp_ovf));
    if (exp_valid && trace_valid) begin
      compare_field("trace_cycle", trace_cycle, exp_rec.cycle);
      compare_field("trace_pc", trace_pc, exp_rec.pc);
      compare_field("trace_instr", trace_instr, exp_rec.instr);
      compare_field("trace_class", 32'(trace_class), 32'(exp_rec.cls));
      compare_field("trace_rd", 32'(trace_rd), 32'(exp_rec.rd));
      compare_field("trace_rd_seen", 32'(trace_rd_seen), 32'(exp_rec.rd_seen));
      if (exp_rec.rd_seen) begin
        compare_field("trace_rd_wdata", trace_rd_wdata, exp_rec.rd_wdata);
      end
      compare_field("trace_mem_valid", 32'(trace_mem_valid), 32'(exp_rec.mem_valid));
      if (exp_rec.mem_valid) begin
        compare_field("trace_mem_we", 32'(trace_mem_we), 32'(exp_rec.mem_we));
        compare_field("trace_mem_addr", trace_mem_addr, exp_rec.mem_addr);
      end
      if (stall_free) begin
        compare_field("trace_valid latency", cyc - trace_cycle, 32'd3);
      end
    end
  endtask

  ////////////////////
  // cycle model
  ////////////////////

  // applies this cycle's inputs to the model, then checks after the edge
  task automatic advance();
    rec_t e;
    rec_t out;
    logic push_id;
    logic pop_ex;
    logic pop_wb;
    e = '0;
    out = '0;
    push_id = is_decoding & (id_valid | pipe_flush | mret | uret | dret | ecall | ebreak);
    e.cycle = cyc;
    e.pc = pc;
    e.instr = instr;
    e.cls = cur_cls;
    e.rd = instr[11:7];
    e.rd_used = uses_rd(cur_cls);
    pop_ex = (id_q.size() > 0) && (ex_valid || wb_bypass);
    if (id_q.size() > 0) begin
      if (ex_reg_we && id_q[0].rd_used && ex_reg_addr == id_q[0].rd && id_q[0].rd != 5'd0) begin
        ex_side.rd_wdata = ex_reg_wdata;
        ex_side.rd_seen = 1'b1;
      end
      if (ex_data_req && ex_data_gnt && !ex_side.mem_valid) begin
        ex_side.mem_valid = 1'b1;
        ex_side.mem_we = ex_data_we;
        ex_side.mem_addr = ex_data_addr;
      end
    end
    if (pop_ex) begin
      out = id_q.pop_front();
      out.rd_wdata = ex_side.rd_wdata;
      out.rd_seen = ex_side.rd_seen;
      out.mem_valid = ex_side.mem_valid;
      out.mem_we = ex_side.mem_we;
      out.mem_addr = ex_side.mem_addr;
      ex_side = '0;
    end
    pop_wb = (wb_q.size() > 0) && wb_valid;
    if (wb_q.size() > 0 && wb_reg_we && wb_q[0].rd_used && wb_reg_addr == wb_q[0].rd &&
        wb_q[0].rd != 5'd0) begin
      wb_side.rd_wdata = wb_reg_wdata;
      wb_side.rd_seen = 1'b1;
    end
    exp_valid = pop_wb;
    if (pop_wb) begin
      exp_rec = wb_q.pop_front();
      // WB value overrides the one from EX
      if (wb_side.rd_seen) begin
        exp_rec.rd_wdata = wb_side.rd_wdata;
        exp_rec.rd_seen = 1'b1;
      end
      wb_side = '0;
    end
    if (pop_ex) begin
      if (wb_q.size() < DEPTH) wb_q.push_back(out);
      else exp_ovf = 1'b1;
    end
    if (push_id) begin
      if (id_q.size() < DEPTH) id_q.push_back(e);
      else exp_ovf = 1'b1;
    end
    cyc = cyc + 32'd1;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic drain();
    clear_capture();
    ex_valid = 1'b1;
    wb_bypass = 1'b0;
    wb_valid = 1'b1;
    while (id_q.size() > 0 || wb_q.size() > 0 || exp_valid) begin
      drive_side();
      advance();
    end
  endtask

  initial begin
    logic [31:0] r;
    init_inputs();
    @(posedge rst_n);

    // each class once, no stalls
    stall_free = 1'b1;
    for (int i = 0; i < 12; i++) begin
      drive_side();
      drive_capture(instr_class_t'(4'(i)));
      ex_valid = 1'b1;
      wb_valid = 1'b1;
      advance();
    end
    drain();
    stall_free = 1'b0;

    // random stalls, bypass and capture triggers
    for (int i = 0; i < RAND_CYCLES; i++) begin
      r = next_rand();
      drive_side();
      case (r[27:25])
        3'd0, 3'd1: drive_capture(instr_class_t'(r[31:28] % 4'd12));
        3'd2: begin
          drive_capture(instr_class_t'(r[31:28] % 4'd12));
          id_valid = 1'b0;
          pipe_flush = 1'b1;
        end
        3'd3: begin
          drive_capture(CLS_SYSTEM);
          id_valid = 1'b0;
          ecall = 1'b1;
        end
        // decoder idle, nothing may be captured
        3'd4: begin
          drive_capture(instr_class_t'(r[31:28] % 4'd12));
          is_decoding = 1'b0;
        end
        default: clear_capture();
      endcase
      ex_valid = (r[24:22] != 3'd0);
      wb_bypass = (r[21:19] == 3'd0);
      wb_valid = (r[18:16] != 3'd0);
      advance();
    end
    drain();

    // EX held, ID queue overflows
    ex_valid = 1'b0;
    wb_bypass = 1'b0;
    wb_valid = 1'b0;
    for (int i = 0; i < DEPTH + 2; i++) begin
      drive_side();
      drive_capture(instr_class_t'(next_rand() % 32'd12));
      advance();
    end
    compare_field("trace_overflow", 32'(trace_overflow), 32'd1);
    drain();
    repeat (3) advance();

    $display("errors: %0d value mismatches, %0d assertion failures",
             value_errors, dut_i.checker_i.fail_count);
    if (value_errors == 0 && dut_i.checker_i.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tracer_checker.sv
// Protocol assertions on the trace outputs, bound into tracer_top.
// fail_count holds the number of failed assertions since time 0.

`timescale 1ns/1ns
`default_nettype none

module tracer_checker import trace_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  trace_valid,
  input logic                  trace_overflow,
  input logic                  trace_rd_seen,
  input logic [REG_ADDR_W-1:0] trace_rd
);

  int fail_count = 0;

  // no record while the unit is held in reset
  valid_low_in_reset: assert property (@(posedge clk) !rst_n |-> !trace_valid)
    else begin
      $error("trace_valid is high while rst_n is low");
      fail_count++;
    end

  // overflow is sticky until the next reset
  overflow_sticky: assert property (
    @(posedge clk) disable iff (!rst_n) $past(trace_overflow) |-> trace_overflow)
    else begin
      $error("trace_overflow fell without a reset");
      fail_count++;
    end

  // x0 is never reported as written
  rd_seen_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n) (trace_valid && trace_rd_seen) |-> (trace_rd != '0))
    else begin
      $error("trace_rd_seen is set for destination x0");
      fail_count++;
    end

endmodule

bind tracer_top tracer_checker checker_i (
  .clk,
  .rst_n,
  .trace_valid,
  .trace_overflow,
  .trace_rd_seen,
  .trace_rd
);

`default_nettype wire
